// ==== hdl/cbm2_timing_pkg.sv ====
// ============================================================
// CBM-II timing package
// Bus slot cycle encoding, slot lengths, refresh spacing,
// TOD divider constants and the strobe bundle
// ============================================================
`default_nettype none

package cbm2_timing_pkg;

   // Slot cycles in bus order, CPU window in the middle, video at the end
   typedef enum logic [4:0] {
      EXT0, EXT1, EXT2, EXT3,
      CPU0, CPU1, CPU2, CPU3,
      EXT4, EXT5, EXT6, EXT7,
      VID0, VID1, VID2, VID3,
      VID4, VID5
   } sys_cycle_t;

   // Last cycle index per model, B slot has two extra video cycles
   localparam int SLOT_LAST_B = 17;
   localparam int SLOT_LAST_P = 15;

   // Refresh fires once per wrap of this counter, every 8 slots
   typedef logic [2:0] rfsh_cnt_t;

   // TOD divider, half periods per second at 60 and 50 Hz
   typedef logic [31:0] tod_acc_t;
   localparam tod_acc_t SYS_CLK_HZ   = 32'd32_000_000;
   localparam tod_acc_t TOD_INC_NTSC = 32'd120;
   localparam tod_acc_t TOD_INC_PAL  = 32'd100;

   // One-cycle enables decoded from the slot
   typedef struct packed {
      logic cpu_ce;
      logic io_ce_n;
      logic io_ce_p;
      logic crtc_ce;
      logic pix_ce;
      logic dot_load;
      logic sys_en;
   } sys_strobes_t;

endpackage

`default_nettype wire

// ==== hdl/cbm2_video_pkg.sv ====
// ============================================================
// CBM-II video package
// CRTC character row, attributes and green channel levels
// ============================================================
`default_nettype none

package cbm2_video_pkg;

   typedef logic [7:0] dot_t;
   typedef logic [7:0] color_t;

   // One character row as seen by the dot shifter
   typedef struct packed {
      dot_t pattern;
      // Video data bit 7 XOR MA13
      logic reverse;
      logic de;
      logic cursor;
      // Repeats bit 0 into the inter-character dot
      logic graphics;
   } crtc_char_t;

   localparam color_t PIX_GREEN_ON = 8'hf8;
   localparam color_t PIX_OFF      = 8'h00;

endpackage

`default_nettype wire

// ==== hdl/cycle_sequencer.sv ====
// ============================================================
// Bus cycle sequencer
// Steps the 18/16 cycle slot, toggles the bus phase, samples
// pause and CPU speed per phase pair and decodes all enables
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module cycle_sequencer (
   input  logic                          clk_sys,
   input  logic                          reset,
   input  logic                          model_i,
   input  logic                          pause_i,
   input  logic                          cpu_2mhz_i,
   output cbm2_timing_pkg::sys_strobes_t strobes_o,
   output cbm2_timing_pkg::sys_cycle_t   cycle_o,
   output logic                          phase_o,
   output logic                          refresh_o,
   output logic                          io_cycle_o,
   output logic                          pause_o
);

   cbm2_timing_pkg::sys_cycle_t pre_cycle;
   cbm2_timing_pkg::sys_cycle_t cycle;
   cbm2_timing_pkg::rfsh_cnt_t  rfsh_cnt;
   logic [4:0]                  slot_last;
   logic                        slot_wrap;
   logic                        phase;
   logic                        sys_en;
   logic                        sys_2mhz;
   logic                        refresh;
   logic                        pix_cnt;
   logic                        cpu_phase;

   // B model runs all 18 cycles, P model stops after VID3
   assign slot_last = model_i ? 5'(cbm2_timing_pkg::SLOT_LAST_B)
                              : 5'(cbm2_timing_pkg::SLOT_LAST_P);
   // Greater-or-equal also catches a model change late in a slot
   assign slot_wrap = pre_cycle >= slot_last;

   // ========================================================
   // Slot counter, phase, sampled controls and refresh
   // ========================================================
   always_ff @(posedge clk_sys) begin
      if (reset) begin
         pre_cycle <= cbm2_timing_pkg::EXT0;
         phase     <= 1'b0;
         sys_en    <= 1'b0;
         sys_2mhz  <= 1'b0;
         rfsh_cnt  <= '0;
         refresh   <= 1'b0;
      end else begin
         refresh <= 1'b0;
         if (slot_wrap) begin
            pre_cycle <= cbm2_timing_pkg::EXT0;
            phase     <= ~phase;
            // Pause and speed only change at the end of a phase pair
            if (phase) begin
               sys_en   <= ~pause_i;
               sys_2mhz <= cpu_2mhz_i;
            end
            // Refresh keeps running while paused
            rfsh_cnt <= rfsh_cnt + 3'd1;
            if (rfsh_cnt == 3'd0) begin
               refresh <= 1'b1;
            end
         end else begin
            pre_cycle <= cbm2_timing_pkg::sys_cycle_t'(pre_cycle + 5'd1);
         end
      end
   end

   // Pixel counter, restarts on each slot and holds while paused
   always_ff @(posedge clk_sys) begin
      if (reset || !sys_en || slot_wrap) begin
         pix_cnt <= 1'b0;
      end else begin
         pix_cnt <= ~pix_cnt;
      end
   end

   // ========================================================
   // Enable decode
   // ========================================================
   // Paused bus sits in EXT0, which decodes to no enables
   assign cycle     = sys_en ? pre_cycle : cbm2_timing_pkg::EXT0;
   // CPU owns every slot in 2 MHz mode, else only phase high
   assign cpu_phase = phase | sys_2mhz;

   always_comb begin
      strobes_o.io_ce_n  = (cycle == cbm2_timing_pkg::CPU2) && cpu_phase;
      strobes_o.cpu_ce   = (cycle == cbm2_timing_pkg::CPU3) && cpu_phase;
      strobes_o.io_ce_p  = (cycle == cbm2_timing_pkg::EXT4) && cpu_phase;
      strobes_o.crtc_ce  = cycle == cbm2_timing_pkg::EXT7;
      strobes_o.pix_ce   = pix_cnt & sys_en;
      // Only reachable in the B model
      strobes_o.dot_load = cycle == cbm2_timing_pkg::VID5;
      strobes_o.sys_en   = sys_en;
   end

   // Loader window, first EXT group yields to refresh slot 1
   assign io_cycle_o = ((cycle <= cbm2_timing_pkg::EXT3) && (rfsh_cnt != 3'd1))
                    || ((cycle >= cbm2_timing_pkg::EXT4) && (cycle <= cbm2_timing_pkg::EXT7));

   assign cycle_o   = cycle;
   assign phase_o   = phase;
   assign refresh_o = refresh;
   assign pause_o   = ~sys_en;

endmodule

`default_nettype wire

// ==== hdl/crtc_dot_shifter.sv ====
// ============================================================
// CRTC dot shifter
// Latches one character row per slot and shifts it out at
// the pixel rate as monochrome green pixels
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module crtc_dot_shifter (
   input  logic                          clk_sys,
   input  logic                          reset,
   input  cbm2_timing_pkg::sys_strobes_t strobes_i,
   input  cbm2_video_pkg::crtc_char_t    char_i,
   output cbm2_video_pkg::color_t        pix_o,
   output logic                          pix_valid_o
);

   cbm2_video_pkg::dot_t dot_q;
   logic                 reverse_q;
   logic                 de_q;
   logic                 cursor_q;
   logic                 graphics_q;
   logic [3:0]           pix_left;
   logic                 pix_on_q;
   logic                 pix_valid_q;
   logic                 pix_step;
   logic                 dot_load;
   logic                 pix_live;
   logic                 pix_next;

   assign pix_step = strobes_i.pix_ce & strobes_i.sys_en;
   assign dot_load = strobes_i.dot_load & strobes_i.sys_en;
   // Nothing to show until a row was loaded
   assign pix_live = pix_step && (pix_left != 4'd0);
   // Cursor inverts everything, reverse only inside the display area
   assign pix_next = cursor_q ^ (de_q & (reverse_q ^ dot_q[7]));

   // Row and attributes, load wins over the shift
   always_ff @(posedge clk_sys) begin
      if (pix_step) begin
         dot_q <= {dot_q[6:0], dot_q[0] & graphics_q};
      end
      if (dot_load) begin
         dot_q      <= char_i.pattern;
         reverse_q  <= char_i.reverse;
         de_q       <= char_i.de;
         cursor_q   <= char_i.cursor;
         graphics_q <= char_i.graphics;
      end
   end

   // Eight dots plus the fill dot per row
   always_ff @(posedge clk_sys) begin
      if (reset) begin
         pix_left    <= 4'd0;
         pix_on_q    <= 1'b0;
         pix_valid_q <= 1'b0;
      end else begin
         pix_valid_q <= pix_live;
         if (pix_live) begin
            pix_on_q <= pix_next;
            pix_left <= pix_left - 4'd1;
         end
         if (dot_load) begin
            pix_left <= 4'd9;
         end
      end
   end

   assign pix_o = pix_on_q ? cbm2_video_pkg::PIX_GREEN_ON : cbm2_video_pkg::PIX_OFF;
   assign pix_valid_o = pix_valid_q;

endmodule

`default_nettype wire

// ==== hdl/tod_clock_gen.sv ====
// ============================================================
// TOD clock generator
// Fractional divider turning the system clock into a 50 or
// 60 Hz square wave, counting only while the system runs
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module tod_clock_gen (
   input  logic clk_sys,
   input  logic reset,
   input  logic sys_en_i,
   input  logic ntsc_i,
   output logic tod_o
);

   cbm2_timing_pkg::tod_acc_t acc;
   cbm2_timing_pkg::tod_acc_t step;
   cbm2_timing_pkg::tod_acc_t sum;
   logic                      tod_q;

   // Two toggles per period, so 120 steps give 60 Hz
   assign step = ntsc_i ? cbm2_timing_pkg::TOD_INC_NTSC : cbm2_timing_pkg::TOD_INC_PAL;
   assign sum  = acc + step;

   always_ff @(posedge clk_sys) begin
      if (reset) begin
         acc   <= '0;
         tod_q <= 1'b0;
      end else if (sys_en_i) begin
         // Overflow past one second of clocks flips the output
         if (sum >= cbm2_timing_pkg::SYS_CLK_HZ) begin
            acc   <= sum - cbm2_timing_pkg::SYS_CLK_HZ;
            tod_q <= ~tod_q;
         end else begin
            acc <= sum;
         end
      end
   end

   assign tod_o = tod_q;

endmodule

`default_nettype wire

// ==== hdl/cbm2_timing_top.sv ====
// ============================================================
// CBM-II timing core top
// Sequencer feeding the CRTC dot shifter and the TOD clock
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module cbm2_timing_top (
   input  logic                       clk_sys,
   input  logic                       reset,
   input  logic                       model_i,
   input  logic                       ntsc_i,
   input  logic                       pause_i,
   input  logic                       cpu_2mhz_i,
   input  cbm2_video_pkg::crtc_char_t char_i,
   output logic                       cpu_ce_o,
   output logic                       io_ce_n_o,
   output logic                       io_ce_p_o,
   output logic                       crtc_ce_o,
   output logic                       io_cycle_o,
   output logic                       refresh_o,
   output logic                       pause_o,
   output logic                       phase_o,
   output cbm2_video_pkg::color_t     pix_o,
   output logic                       pix_valid_o,
   output logic                       tod_o
);

   cbm2_timing_pkg::sys_strobes_t strobes;

   // Slot sequencer and enable decode
   cycle_sequencer seq_i (
      .clk_sys    (clk_sys),
      .reset      (reset),
      .model_i    (model_i),
      .pause_i    (pause_i),
      .cpu_2mhz_i (cpu_2mhz_i),
      .strobes_o  (strobes),
      .cycle_o    (),
      .phase_o    (phase_o),
      .refresh_o  (refresh_o),
      .io_cycle_o (io_cycle_o),
      .pause_o    (pause_o)
   );

   // B model text pixels
   crtc_dot_shifter shifter_i (
      .clk_sys     (clk_sys),
      .reset       (reset),
      .strobes_i   (strobes),
      .char_i      (char_i),
      .pix_o       (pix_o),
      .pix_valid_o (pix_valid_o)
   );

   tod_clock_gen tod_i (
      .clk_sys  (clk_sys),
      .reset    (reset),
      .sys_en_i (strobes.sys_en),
      .ntsc_i   (ntsc_i),
      .tod_o    (tod_o)
   );

   assign cpu_ce_o  = strobes.cpu_ce;
   assign io_ce_n_o = strobes.io_ce_n;
   assign io_ce_p_o = strobes.io_ce_p;
   assign crtc_ce_o = strobes.crtc_ce;

endmodule

`default_nettype wire

// ==== verif/tb_cbm2_timing.sv ====
// ============================================================
// CBM-II timing core testbench
// Refresh spacing, CPU and I/O enables, pause, dot shifter
// pixels and TOD toggle count against reference values
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module tb_cbm2_timing;

   localparam int DOT_CHARS       = 48;
   // NTSC and PAL lengths where the wrong step changes the toggle count
   localparam int TOD_NTSC_CYCLES = 280_000;
   localparam int TOD_PAL_CYCLES  = 560_000;
   // Both TOD runs plus the dot rows and a margin for the short tests
   localparam int WATCHDOG_CYCLES = TOD_NTSC_CYCLES + TOD_PAL_CYCLES
                                  + (DOT_CHARS + 2) * 18 + 20_000;

   typedef enum int {W_REFRESH, W_IO_CE_N, W_PAUSED, W_RUNNING, W_CRTC_CE} wait_sel_t;

   logic                       clk_sys = 1'b0;
   logic                       reset;
   logic                       model;
   logic                       ntsc;
   logic                       pause;
   logic                       cpu_2mhz;
   cbm2_video_pkg::crtc_char_t chr;
   logic                       cpu_ce;
   logic                       io_ce_n;
   logic                       io_ce_p;
   logic                       crtc_ce;
   logic                       io_cycle;
   logic                       refresh;
   logic                       paused;
   logic                       phase;
   cbm2_video_pkg::color_t     pix;
   logic                       pix_valid;
   logic                       tod;
   // Error counts per process and pixel bookkeeping
   int                         stim_errors;
   int                         pix_errors;
   int                         pix_checked;
   int                         pix_pulses;
   int                         pix_idx;
   logic                       dot_check_on;
   cbm2_video_pkg::crtc_char_t char_d1;
   cbm2_video_pkg::crtc_char_t char_d2;
   cbm2_video_pkg::crtc_char_t char_d3;
   cbm2_video_pkg::crtc_char_t row_char;

   always #2 clk_sys = ~clk_sys;

   cbm2_timing_top dut_i (
      .clk_sys     (clk_sys),
      .reset       (reset),
      .model_i     (model),
      .ntsc_i      (ntsc),
      .pause_i     (pause),
      .cpu_2mhz_i  (cpu_2mhz),
      .char_i      (chr),
      .cpu_ce_o    (cpu_ce),
      .io_ce_n_o   (io_ce_n),
      .io_ce_p_o   (io_ce_p),
      .crtc_ce_o   (crtc_ce),
      .io_cycle_o  (io_cycle),
      .refresh_o   (refresh),
      .pause_o     (paused),
      .phase_o     (phase),
      .pix_o       (pix),
      .pix_valid_o (pix_valid),
      .tod_o       (tod)
   );

   // ========================================================
   // Reference model and check helpers
   // ========================================================
   // Dots 7..0 first and then the inter-character dot
   function automatic cbm2_video_pkg::color_t expected_pixel(
      input cbm2_video_pkg::crtc_char_t c, input int idx);
      logic dot;
      logic lit;
      // Ninth dot repeats bit 0 only for graphics characters
      dot = (idx == 8) ? (c.pattern[0] & c.graphics) : c.pattern[3'(7 - idx)];
      lit = c.cursor ^ (c.de & (c.reverse ^ dot));
      return lit ? cbm2_video_pkg::PIX_GREEN_ON : cbm2_video_pkg::PIX_OFF;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp, inout int errs);
      if (got !== exp) begin
         errs++;
         $display("Mismatch at %0t ns: %s got %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   function automatic logic strobe(input wait_sel_t sel);
      case (sel)
         W_REFRESH: return refresh;
         W_IO_CE_N: return io_ce_n;
         W_PAUSED:  return paused;
         W_RUNNING: return !paused;
         default:   return crtc_ce;
      endcase
   endfunction

   // Counts falling edges until the strobe is seen or the limit is reached
   task automatic wait_for(input wait_sel_t sel, input int limit, output int waited);
      waited = 0;
      do begin
         @(negedge clk_sys);
         waited++;
      end while (!strobe(sel) && waited < limit);
      if (!strobe(sel)) begin
         stim_errors++;
         $display("Timed out after %0d cycles waiting for %s", limit, sel.name());
      end
   endtask

   task automatic apply_reset();
      reset = 1'b1;
      repeat (5) @(negedge clk_sys);
      reset = 1'b0;
   endtask

   // io_ce_n, cpu_ce, io_ce_p on three cycles in a row, crtc_ce in EXT7
   task automatic check_enable_slot(input int slot_gap);
      int gap;
      wait_for(W_IO_CE_N, 40, gap);
      // Five cycles of the previous slot were spent on the order check
      if (slot_gap != 0) begin
         check_value("io_ce_n_o spacing", gap + 5, slot_gap, stim_errors);
      end
      // Without 2 MHz the CPU only owns the high phase
      if (!cpu_2mhz) begin
         check_value("phase_o", 32'(phase), 1, stim_errors);
      end
      // CPU window is no loader cycle
      check_value("io_cycle_o", 32'(io_cycle), 0, stim_errors);
      @(negedge clk_sys);
      check_value("cpu_ce_o", 32'(cpu_ce), 1, stim_errors);
      @(negedge clk_sys);
      check_value("io_ce_p_o", 32'(io_ce_p), 1, stim_errors);
      check_value("io_cycle_o", 32'(io_cycle), 1, stim_errors);
      repeat (3) @(negedge clk_sys);
      check_value("crtc_ce_o", 32'(crtc_ce), 1, stim_errors);
   endtask

   // TOD toggles against floor(running cycles * step / clock rate)
   task automatic run_tod(input logic ntsc_sel, input int cycles);
      int                        run;
      int                        toggles;
      logic                      tod_prev;
      cbm2_timing_pkg::tod_acc_t step;
      ntsc = ntsc_sel;
      apply_reset();
      run = 0;
      toggles = 0;
      tod_prev = tod;
      repeat (cycles) begin
         // A running cycle adds its step on the next rising edge
         if (!paused) run++;
         @(negedge clk_sys);
         if (tod !== tod_prev) toggles++;
         tod_prev = tod;
      end
      step = ntsc_sel ? cbm2_timing_pkg::TOD_INC_NTSC : cbm2_timing_pkg::TOD_INC_PAL;
      check_value("tod_o toggles", toggles,
                  32'((64'(run) * 64'(step)) / 64'(cbm2_timing_pkg::SYS_CLK_HZ)), stim_errors);
   endtask

   // ========================================================
   // Pixel compare process
   // ========================================================
   always @(posedge clk_sys) begin
      if (pix_valid) pix_pulses++;
      if (dot_check_on && pix_valid) begin
         if (pix_idx == 0) row_char = char_d3;
         check_value("pix_o", 32'(pix), 32'(expected_pixel(row_char, pix_idx)), pix_errors);
         pix_checked++;
         pix_idx = (pix_idx == 8) ? 0 : pix_idx + 1;
      end else if (!dot_check_on) begin
         pix_idx = 0;
      end
      // Row loaded at VID5 shows its first pixel three edges later
      char_d3 = char_d2;
      char_d2 = char_d1;
      char_d1 = chr;
   end

   // ========================================================
   // Stimulus
   // ========================================================
   initial begin
      int gap;
      int busy;
      int rfsh_seen;
      void'($urandom(32'h8037_89a7));
      model = 1'b0;
      ntsc = 1'b1;
      pause = 1'b0;
      cpu_2mhz = 1'b0;
      chr = '0;
      dot_check_on = 1'b0;
      apply_reset();

      // P model refresh spacing while the shifter never loads
      wait_for(W_RUNNING, 40, gap);
      wait_for(W_REFRESH, 200, gap);
      repeat (2) begin
         wait_for(W_REFRESH, 200, gap);
         check_value("refresh_o spacing", gap, 8 * 16, stim_errors);
      end
      check_value("pix_valid_o pulses", pix_pulses, 0, stim_errors);
      check_value("pix_o", 32'(pix), 32'(cbm2_video_pkg::PIX_OFF), stim_errors);

      // B model refresh spacing
      model = 1'b1;
      wait_for(W_REFRESH, 200, gap);
      repeat (2) begin
         wait_for(W_REFRESH, 200, gap);
         check_value("refresh_o spacing", gap, 8 * 18, stim_errors);
         // First EXT group of the refresh slot belongs to refresh
         check_value("io_cycle_o", 32'(io_cycle), 0, stim_errors);
      end
      repeat (18) @(negedge clk_sys);
      check_value("io_cycle_o", 32'(io_cycle), 1, stim_errors);

      // 1 MHz CPU gets every other slot and 2 MHz every slot
      check_enable_slot(0);
      repeat (3) check_enable_slot(36);
      cpu_2mhz = 1'b1;
      repeat (2) check_enable_slot(0);
      repeat (3) check_enable_slot(18);

      // Pause freezes the bus but not refresh
      pause = 1'b1;
      wait_for(W_PAUSED, 36, gap);
      // Last pixel of the row still drains in the first paused cycle
      @(negedge clk_sys);
      busy = 0;
      rfsh_seen = 0;
      repeat (20 * 18) begin
         if (cpu_ce || io_ce_n || io_ce_p || crtc_ce || pix_valid) busy++;
         if (refresh) rfsh_seen++;
         @(negedge clk_sys);
      end
      check_value("enables while paused", busy, 0, stim_errors);
      check_value("refresh_o while paused", 32'(rfsh_seen >= 2), 1, stim_errors);
      pause = 1'b0;
      wait_for(W_RUNNING, 36, gap);

      // New character at cycle 0 of each slot and the attributes walk all 16 cases
      wait_for(W_CRTC_CE, 40, gap);
      repeat (7) @(negedge clk_sys);
      for (int i = 0; i < DOT_CHARS; i++) begin
         chr.pattern = 8'($urandom);
         {chr.reverse, chr.de, chr.cursor, chr.graphics} = 4'(i);
         @(negedge clk_sys);
         dot_check_on = 1'b1;
         repeat (17) @(negedge clk_sys);
      end
      repeat (19) @(negedge clk_sys);
      dot_check_on = 1'b0;
      check_value("pixels checked", pix_checked, 9 * (DOT_CHARS + 1), stim_errors);

      run_tod(1'b1, TOD_NTSC_CYCLES);
      run_tod(1'b0, TOD_PAL_CYCLES);

      $display("Errors: %0d stimulus, %0d pixel, %0d total",
               stim_errors, pix_errors, stim_errors + pix_errors);
      if (stim_errors + pix_errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * 4);
      $display("Watchdog expired after %0d cycles, a test never finished", WATCHDOG_CYCLES);
      $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim.f ====
hdl/cbm2_timing_pkg.sv
hdl/cbm2_video_pkg.sv
hdl/cycle_sequencer.sv
hdl/crtc_dot_shifter.sv
hdl/tod_clock_gen.sv
hdl/cbm2_timing_top.sv
verif/tb_cbm2_timing.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the CBM-II timing testbench with Verilator
set -e
cd "$(dirname "$0")"

TOP=tb_cbm2_timing
LOG=sim.log

verilator --binary --timing \
   --top-module "$TOP" \
   -f sim.f \
   -o "V$TOP"

./obj_dir/"V$TOP" > "$LOG"
cat "$LOG"

if grep -q "TB PASSED" "$LOG"; then
   echo "Simulation passed"
else
   echo "Simulation failed, see $LOG"
   exit 1
fi
